//--- hdl/dac_tpl_pkg.sv
// ************************************************
// DAC transport layer shared definitions
// Widths, register map addresses and select codes
// ************************************************

package dac_tpl_pkg;

  // Widths
  localparam int UP_ADDR_W  = 10;
  localparam int SAMPLE_W   = 16;
  localparam int DATA_SEL_W = 4;

  typedef logic [UP_ADDR_W-1:0]  up_addr_t;
  typedef logic [31:0]           up_data_t;
  typedef logic [SAMPLE_W-1:0]   sample_t;
  typedef logic [DATA_SEL_W-1:0] data_sel_t;

  localparam up_data_t CORE_VERSION = 32'h0001_0061;

  // ************************************************
  // Common register addresses
  // ************************************************
  localparam up_addr_t REG_VERSION  = 10'h000;
  localparam up_addr_t REG_SCRATCH  = 10'h002;
  localparam up_addr_t REG_CHAN_CNT = 10'h003;
  localparam up_addr_t REG_RSTN     = 10'h010;
  localparam up_addr_t REG_SYNC     = 10'h011;
  localparam up_addr_t REG_FORMAT   = 10'h012;
  localparam up_addr_t REG_STATUS   = 10'h022;

  // ************************************************
  // Channel region layout
  // ************************************************
  localparam up_addr_t CHAN_BASE   = 10'h100;
  localparam up_addr_t CHAN_STRIDE = 10'h010;

  // Offsets inside one channel window
  localparam logic [3:0] CH_SEL  = 4'h0;
  localparam logic [3:0] CH_INCR = 4'h1;
  localparam logic [3:0] CH_INIT = 4'h2;
  localparam logic [3:0] CH_PAT  = 4'h3;

  // Source select codes
  localparam data_sel_t SEL_RAMP    = 4'd0;
  localparam data_sel_t SEL_PATTERN = 4'd1;
  localparam data_sel_t SEL_EXT     = 4'd2;

endpackage

//--- hdl/dac_tpl_common_regs.sv
// ************************************************
// DAC transport layer common registers
// Run, sync, format, scratch, version and the
// sticky underflow status
// ************************************************

`timescale 1ns/1ps

module dac_tpl_common_regs import dac_tpl_pkg::*; #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic     up_clk,
  input  logic     up_rstn,

  input  logic     up_wreq,
  input  up_addr_t up_waddr,
  input  up_data_t up_wdata,
  output logic     up_wack,
  input  logic     up_rreq,
  input  up_addr_t up_raddr,
  output up_data_t up_rdata,
  output logic     up_rack,

  input  logic     dac_dunf,
  output logic     dac_run,
  output logic     dac_sync,
  output logic     dac_format
);

  logic     up_wsel;
  logic     up_rsel;
  up_data_t up_scratch;
  logic     up_dunf_sticky;
  up_data_t up_rdata_mux;

  // Only the listed registers are owned, holes stay unacknowledged
  function automatic logic is_common_reg(input up_addr_t addr);
    case (addr)
      REG_VERSION, REG_SCRATCH, REG_CHAN_CNT, REG_RSTN,
      REG_SYNC, REG_FORMAT, REG_STATUS: is_common_reg = 1'b1;
      default: is_common_reg = 1'b0;
    endcase
  endfunction

  assign up_wsel = up_wreq && is_common_reg(up_waddr);
  assign up_rsel = up_rreq && is_common_reg(up_raddr);

  // ************************************************
  // Write side
  // ************************************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack        <= 1'b0;
      dac_run        <= 1'b0;
      dac_sync       <= 1'b0;
      dac_format     <= 1'b0;
      up_dunf_sticky <= 1'b0;
    end else begin
      up_wack  <= up_wsel;
      // Sync clears itself after one cycle
      dac_sync <= up_wsel && (up_waddr == REG_SYNC) && up_wdata[0];
      if (up_wsel && (up_waddr == REG_RSTN)) begin
        dac_run <= up_wdata[0];
      end
      if (up_wsel && (up_waddr == REG_FORMAT)) begin
        dac_format <= up_wdata[0];
      end
      // W1C; a new underflow in the same cycle still sets the flag
      if (up_wsel && (up_waddr == REG_STATUS) && up_wdata[0]) begin
        up_dunf_sticky <= dac_dunf;
      end else begin
        up_dunf_sticky <= up_dunf_sticky | dac_dunf;
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (up_wsel && (up_waddr == REG_SCRATCH)) begin
      up_scratch <= up_wdata;
    end
  end

  // ************************************************
  // Read side
  // ************************************************
  always_comb begin
    case (up_raddr)
      REG_VERSION:  up_rdata_mux = CORE_VERSION;
      REG_SCRATCH:  up_rdata_mux = up_scratch;
      REG_CHAN_CNT: up_rdata_mux = up_data_t'(NUM_CHANNELS);
      REG_RSTN:     up_rdata_mux = {31'd0, dac_run};
      REG_FORMAT:   up_rdata_mux = {31'd0, dac_format};
      REG_STATUS:   up_rdata_mux = {31'd0, up_dunf_sticky};
      default:      up_rdata_mux = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rsel;
      up_rdata <= up_rsel ? up_rdata_mux : '0;
    end
  end

endmodule

//--- hdl/dac_tpl_channel_regs.sv
// ************************************************
// DAC transport layer channel registers
// Source select, ramp and pattern settings of one
// channel in its own 16 word window
// ************************************************

`timescale 1ns/1ps

module dac_tpl_channel_regs import dac_tpl_pkg::*; #(
  parameter int CHANNEL_ID = 0
) (
  input  logic      up_clk,
  input  logic      up_rstn,

  input  logic      up_wreq,
  input  up_addr_t  up_waddr,
  input  up_data_t  up_wdata,
  output logic      up_wack,
  input  logic      up_rreq,
  input  up_addr_t  up_raddr,
  output up_data_t  up_rdata,
  output logic      up_rack,

  output data_sel_t dac_data_sel,
  output sample_t   dac_ramp_incr,
  output sample_t   dac_ramp_init,
  output sample_t   dac_pat_data_0,
  output sample_t   dac_pat_data_1
);

  // Window start of this channel
  localparam up_addr_t WIN_ADDR = up_addr_t'(CHAN_BASE + CHANNEL_ID * CHAN_STRIDE);

  logic       up_wsel;
  logic       up_rsel;
  logic [3:0] up_woff;
  logic [3:0] up_roff;
  up_data_t   up_rdata_mux;

  assign up_wsel = up_wreq && (up_waddr[UP_ADDR_W-1:4] == WIN_ADDR[UP_ADDR_W-1:4]);
  assign up_rsel = up_rreq && (up_raddr[UP_ADDR_W-1:4] == WIN_ADDR[UP_ADDR_W-1:4]);
  assign up_woff = up_waddr[3:0];
  assign up_roff = up_raddr[3:0];

  // ************************************************
  // Write side
  // ************************************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack        <= 1'b0;
      dac_data_sel   <= '0;
      dac_ramp_incr  <= '0;
      dac_ramp_init  <= '0;
      dac_pat_data_0 <= '0;
      dac_pat_data_1 <= '0;
    end else begin
      up_wack <= up_wsel;
      if (up_wsel) begin
        case (up_woff)
          CH_SEL:  dac_data_sel  <= up_wdata[DATA_SEL_W-1:0];
          CH_INCR: dac_ramp_incr <= up_wdata[SAMPLE_W-1:0];
          CH_INIT: dac_ramp_init <= up_wdata[SAMPLE_W-1:0];
          CH_PAT: begin
            dac_pat_data_0 <= up_wdata[15:0];
            dac_pat_data_1 <= up_wdata[31:16];
          end
          default: ;
        endcase
      end
    end
  end

  // ************************************************
  // Read side
  // ************************************************
  always_comb begin
    case (up_roff)
      CH_SEL:  up_rdata_mux = up_data_t'(dac_data_sel);
      CH_INCR: up_rdata_mux = up_data_t'(dac_ramp_incr);
      CH_INIT: up_rdata_mux = up_data_t'(dac_ramp_init);
      CH_PAT:  up_rdata_mux = {dac_pat_data_1, dac_pat_data_0};
      default: up_rdata_mux = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rsel;
      up_rdata <= up_rsel ? up_rdata_mux : '0;
    end
  end

endmodule

//--- hdl/dac_tpl_chan_source.sv
// ************************************************
// DAC transport layer channel sample source
// Ramp, two word pattern or external data with
// optional offset binary conversion
// ************************************************

`timescale 1ns/1ps

module dac_tpl_chan_source import dac_tpl_pkg::*; (
  input  logic      up_clk,
  input  logic      up_rstn,

  input  logic      dac_run,
  input  logic      dac_sync,
  input  logic      dac_format,

  input  data_sel_t dac_data_sel,
  input  sample_t   dac_ramp_incr,
  input  sample_t   dac_ramp_init,
  input  sample_t   dac_pat_data_0,
  input  sample_t   dac_pat_data_1,

  input  sample_t   ext_data,
  output sample_t   dac_data
);

  sample_t ramp_phase;
  logic    pat_sel;
  sample_t src_sample;
  sample_t fmt_sample;

  // ************************************************
  // Source state
  // ************************************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ramp_phase <= '0;
      pat_sel    <= 1'b0;
    end else if (!dac_run || dac_sync) begin
      // Hold at the start point so all channels line up
      ramp_phase <= dac_ramp_init;
      pat_sel    <= 1'b0;
    end else begin
      ramp_phase <= ramp_phase + dac_ramp_incr;
      pat_sel    <= ~pat_sel;
    end
  end

  // Source mux
  always_comb begin
    case (dac_data_sel)
      SEL_RAMP:    src_sample = ramp_phase;
      SEL_PATTERN: src_sample = pat_sel ? dac_pat_data_1 : dac_pat_data_0;
      SEL_EXT:     src_sample = ext_data;
      default:     src_sample = '0;
    endcase
  end

  // Offset binary flips the sign bit
  assign fmt_sample = {src_sample[SAMPLE_W-1] ^ dac_format, src_sample[SAMPLE_W-2:0]};

  // ************************************************
  // Output register
  // ************************************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      dac_data <= '0;
    end else begin
      dac_data <= fmt_sample;
    end
  end

endmodule

//--- hdl/dac_tpl_regmap.sv
// ************************************************
// DAC transport layer register map
// Fans the bus out to the register blocks and
// merges their read data and acknowledges
// ************************************************

`timescale 1ns/1ps

module dac_tpl_regmap import dac_tpl_pkg::*; #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                             up_clk,
  input  logic                             up_rstn,

  input  logic                             up_wreq,
  input  up_addr_t                         up_waddr,
  input  up_data_t                         up_wdata,
  output logic                             up_wack,
  input  logic                             up_rreq,
  input  up_addr_t                         up_raddr,
  output up_data_t                         up_rdata,
  output logic                             up_rack,

  input  logic                             dac_dunf,
  output logic                             dac_run,
  output logic                             dac_sync,
  output logic                             dac_format,

  output logic [NUM_CHANNELS*DATA_SEL_W-1:0] dac_data_sel,
  output logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_ramp_incr,
  output logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_ramp_init,
  output logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_pat_data_0,
  output logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_pat_data_1
);

  // Slot 0 is the common block, slot i+1 is channel i
  logic [NUM_CHANNELS:0] up_wack_s;
  logic [NUM_CHANNELS:0] up_rack_s;
  up_data_t              up_rdata_s [0:NUM_CHANNELS];
  up_data_t              up_rdata_all;

  always_comb begin
    up_rdata_all = '0;
    for (int n = 0; n <= NUM_CHANNELS; n++) begin
      up_rdata_all = up_rdata_all | up_rdata_s[n];
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= |up_wack_s;
      up_rack  <= |up_rack_s;
      up_rdata <= up_rdata_all;
    end
  end

  // ************************************************
  // Register blocks
  // ************************************************
  dac_tpl_common_regs #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) i_common_regs (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack_s[0]),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata_s[0]),
    .up_rack    (up_rack_s[0]),
    .dac_dunf   (dac_dunf),
    .dac_run    (dac_run),
    .dac_sync   (dac_sync),
    .dac_format (dac_format)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    dac_tpl_channel_regs #(
      .CHANNEL_ID (i)
    ) i_channel_regs (
      .up_clk         (up_clk),
      .up_rstn        (up_rstn),
      .up_wreq        (up_wreq),
      .up_waddr       (up_waddr),
      .up_wdata       (up_wdata),
      .up_wack        (up_wack_s[i+1]),
      .up_rreq        (up_rreq),
      .up_raddr       (up_raddr),
      .up_rdata       (up_rdata_s[i+1]),
      .up_rack        (up_rack_s[i+1]),
      .dac_data_sel   (dac_data_sel[i*DATA_SEL_W +: DATA_SEL_W]),
      .dac_ramp_incr  (dac_ramp_incr[i*SAMPLE_W +: SAMPLE_W]),
      .dac_ramp_init  (dac_ramp_init[i*SAMPLE_W +: SAMPLE_W]),
      .dac_pat_data_0 (dac_pat_data_0[i*SAMPLE_W +: SAMPLE_W]),
      .dac_pat_data_1 (dac_pat_data_1[i*SAMPLE_W +: SAMPLE_W])
    );
  end

endmodule

//--- hdl/dac_tpl_top.sv
// ************************************************
// DAC transport layer top level
// Register map driving one sample source per channel
// ************************************************

`timescale 1ns/1ps

module dac_tpl_top import dac_tpl_pkg::*; #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                           up_clk,
  input  logic                           up_rstn,

  input  logic                           up_wreq,
  input  up_addr_t                       up_waddr,
  input  up_data_t                       up_wdata,
  output logic                           up_wack,
  input  logic                           up_rreq,
  input  up_addr_t                       up_raddr,
  output up_data_t                       up_rdata,
  output logic                           up_rack,

  input  logic                           dac_dunf,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0] ext_data,
  output logic [NUM_CHANNELS*SAMPLE_W-1:0] dac_data
);

  logic                               dac_run;
  logic                               dac_sync;
  logic                               dac_format;
  logic [NUM_CHANNELS*DATA_SEL_W-1:0] dac_data_sel;
  logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_ramp_incr;
  logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_ramp_init;
  logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_pat_data_0;
  logic [NUM_CHANNELS*SAMPLE_W-1:0]   dac_pat_data_1;

  dac_tpl_regmap #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) i_regmap (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_wreq        (up_wreq),
    .up_waddr       (up_waddr),
    .up_wdata       (up_wdata),
    .up_wack        (up_wack),
    .up_rreq        (up_rreq),
    .up_raddr       (up_raddr),
    .up_rdata       (up_rdata),
    .up_rack        (up_rack),
    .dac_dunf       (dac_dunf),
    .dac_run        (dac_run),
    .dac_sync       (dac_sync),
    .dac_format     (dac_format),
    .dac_data_sel   (dac_data_sel),
    .dac_ramp_incr  (dac_ramp_incr),
    .dac_ramp_init  (dac_ramp_init),
    .dac_pat_data_0 (dac_pat_data_0),
    .dac_pat_data_1 (dac_pat_data_1)
  );

  // One source per channel, all sharing run, sync and format
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_source
    dac_tpl_chan_source i_chan_source (
      .up_clk         (up_clk),
      .up_rstn        (up_rstn),
      .dac_run        (dac_run),
      .dac_sync       (dac_sync),
      .dac_format     (dac_format),
      .dac_data_sel   (dac_data_sel[i*DATA_SEL_W +: DATA_SEL_W]),
      .dac_ramp_incr  (dac_ramp_incr[i*SAMPLE_W +: SAMPLE_W]),
      .dac_ramp_init  (dac_ramp_init[i*SAMPLE_W +: SAMPLE_W]),
      .dac_pat_data_0 (dac_pat_data_0[i*SAMPLE_W +: SAMPLE_W]),
      .dac_pat_data_1 (dac_pat_data_1[i*SAMPLE_W +: SAMPLE_W]),
      .ext_data       (ext_data[i*SAMPLE_W +: SAMPLE_W]),
      .dac_data       (dac_data[i*SAMPLE_W +: SAMPLE_W])
    );
  end

endmodule

//--- test/dac_tpl_tb.sv
// ************************************************
// DAC transport layer testbench
// Directed tests of the register map, the sample
// sources, sync, format and the underflow flag
// ************************************************

`timescale 1ns/1ps

module dac_tpl_tb import dac_tpl_pkg::*;;

  localparam int NUM_CH = 2;

  logic                       up_clk;
  logic                       up_rstn;
  logic                       up_wreq;
  up_addr_t                   up_waddr;
  up_data_t                   up_wdata;
  logic                       up_wack;
  logic                       up_rreq;
  up_addr_t                   up_raddr;
  up_data_t                   up_rdata;
  logic                       up_rack;
  logic                       dac_dunf;
  logic [NUM_CH*SAMPLE_W-1:0] ext_data;
  logic [NUM_CH*SAMPLE_W-1:0] dac_data;
  integer                     seed;

  dac_tpl_top #(
    .NUM_CHANNELS (NUM_CH)
  ) uut (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .dac_dunf (dac_dunf),
    .ext_data (ext_data),
    .dac_data (dac_data)
  );

  always #5 up_clk = ~up_clk;

  // ************************************************
  // Helpers
  // ************************************************
  // Next rising edge plus the drive delay
  task automatic tick();
    @(posedge up_clk);
    #1;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string name, input up_data_t got, input up_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s got 0x%08h, expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  function automatic up_addr_t chan_addr(input int ch, input logic [3:0] off);
    chan_addr = up_addr_t'(CHAN_BASE + ch * CHAN_STRIDE + off);
  endfunction

  function automatic sample_t chan_sample(input int ch);
    chan_sample = dac_data[ch*SAMPLE_W +: SAMPLE_W];
  endfunction

  task automatic up_write(input up_addr_t addr, input up_data_t data);
    int n;
    up_waddr = addr;
    up_wdata = data;
    up_wreq  = 1'b1;
    tick();
    up_wreq  = 1'b0;
    n = 0;
    while (!up_wack && n < 16) begin
      tick();
      n++;
    end
    if (!up_wack) begin
      abort_run($sformatf("Write to address 0x%03h was never acknowledged", addr));
    end
  endtask

  task automatic up_read(input up_addr_t addr, output up_data_t data);
    int n;
    up_raddr = addr;
    up_rreq  = 1'b1;
    tick();
    up_rreq  = 1'b0;
    n = 0;
    while (!up_rack && n < 16) begin
      tick();
      n++;
    end
    if (!up_rack) begin
      abort_run($sformatf("Read of address 0x%03h was never acknowledged", addr));
    end
    data = up_rdata;
  endtask

  task automatic read_expect(input string name, input up_addr_t addr, input up_data_t exp);
    up_data_t data;
    up_read(addr, data);
    check(name, data, exp);
  endtask

  // Unowned addresses must stay silent
  task automatic read_expect_no_ack(input up_addr_t addr);
    up_raddr = addr;
    up_rreq  = 1'b1;
    tick();
    up_rreq  = 1'b0;
    for (int n = 0; n < 8; n++) begin
      if (up_rack) begin
        abort_run($sformatf("Read of unmapped address 0x%03h was acknowledged", addr));
      end
      tick();
    end
  endtask

  // ************************************************
  // Tests
  // ************************************************
  task automatic test_register_access();
    check("up_wack", up_data_t'(up_wack), 32'd0);
    check("up_rack", up_data_t'(up_rack), 32'd0);
    check("dac_data", dac_data, 32'd0);
    read_expect("REG_VERSION", REG_VERSION, 32'h0001_0061);
    read_expect("REG_CHAN_CNT", REG_CHAN_CNT, 32'd2);
    up_write(REG_SCRATCH, 32'ha5c3_5a3c);
    read_expect("REG_SCRATCH", REG_SCRATCH, 32'ha5c3_5a3c);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      // Upper bits of the 16 bit registers are dropped
      up_write(chan_addr(ch, CH_INCR), 32'hdead_1357 + ch);
      up_write(chan_addr(ch, CH_INIT), 32'hbeef_2468 + ch);
      up_write(chan_addr(ch, CH_PAT), 32'h9abc_0def + ch);
      read_expect("CH_INCR", chan_addr(ch, CH_INCR), 32'h0000_1357 + ch);
      read_expect("CH_INIT", chan_addr(ch, CH_INIT), 32'h0000_2468 + ch);
      read_expect("CH_PAT", chan_addr(ch, CH_PAT), 32'h9abc_0def + ch);
    end
    read_expect_no_ack(10'h0f0);
  endtask

  task automatic test_ramp();
    sample_t init_val;
    sample_t incr_val;
    sample_t expected;
    init_val = 16'hfe10;
    incr_val = 16'h0357;
    up_write(chan_addr(0, CH_SEL), up_data_t'(SEL_RAMP));
    up_write(chan_addr(0, CH_INCR), up_data_t'(incr_val));
    up_write(chan_addr(0, CH_INIT), up_data_t'(init_val));
    up_write(REG_RSTN, 32'd1);
    check("dac_data[0] ramp start", up_data_t'(chan_sample(0)), up_data_t'(init_val));
    expected = init_val;
    repeat (32) begin
      tick();
      expected = expected + incr_val;
      check("dac_data[0] ramp step", up_data_t'(chan_sample(0)), up_data_t'(expected));
    end
  endtask

  task automatic test_pattern_sync();
    sample_t pat0;
    sample_t pat1;
    sample_t cur;
    sample_t prev [0:NUM_CH-1];
    sample_t init_val;
    sample_t incr_val;
    sample_t expected;
    pat0 = 16'h5a3c;
    pat1 = 16'hc3a5;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      up_write(chan_addr(ch, CH_PAT), {pat1, pat0});
      up_write(chan_addr(ch, CH_SEL), up_data_t'(SEL_PATTERN));
    end
    tick();
    for (int n = 0; n < 16; n++) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        cur = chan_sample(ch);
        if (n == 0) begin
          check("dac_data pattern word", up_data_t'((cur == pat0) || (cur == pat1)), 32'd1);
        end else begin
          check("dac_data pattern", up_data_t'(cur), up_data_t'((prev[ch] == pat0) ? pat1 : pat0));
        end
        prev[ch] = cur;
      end
      tick();
    end

    // Equal ramp settings on both channels before the realign
    init_val = 16'h4000;
    incr_val = 16'h0011;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      up_write(chan_addr(ch, CH_INIT), up_data_t'(init_val));
      up_write(chan_addr(ch, CH_INCR), up_data_t'(incr_val));
      up_write(chan_addr(ch, CH_SEL), up_data_t'(SEL_RAMP));
    end
    up_write(REG_SYNC, 32'd1);
    tick();
    expected = init_val;
    repeat (8) begin
      check("dac_data[0] after sync", up_data_t'(chan_sample(0)), up_data_t'(expected));
      check("dac_data[1] after sync", up_data_t'(chan_sample(1)), up_data_t'(expected));
      expected = expected + incr_val;
      tick();
    end
  endtask

  task automatic test_ext_format();
    sample_t sent [0:NUM_CH-1];
    sample_t flip;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      up_write(chan_addr(ch, CH_SEL), up_data_t'(SEL_EXT));
    end
    for (int fmt = 0; fmt < 2; fmt++) begin
      up_write(REG_FORMAT, up_data_t'(fmt));
      flip = (fmt == 1) ? 16'h8000 : 16'h0000;
      repeat (16) begin
        ext_data = $random(seed);
        for (int ch = 0; ch < NUM_CH; ch++) begin
          sent[ch] = ext_data[ch*SAMPLE_W +: SAMPLE_W];
        end
        tick();
        for (int ch = 0; ch < NUM_CH; ch++) begin
          check("dac_data ext", up_data_t'(chan_sample(ch)), up_data_t'(sent[ch] ^ flip));
        end
      end
    end
    // Unused select code
    up_write(REG_FORMAT, 32'd0);
    up_write(chan_addr(0, CH_SEL), 32'd5);
    tick();
    check("dac_data[0] unused select", up_data_t'(chan_sample(0)), 32'd0);
  endtask

  task automatic test_underflow();
    read_expect("REG_STATUS idle", REG_STATUS, 32'd0);
    dac_dunf = 1'b1;
    tick();
    dac_dunf = 1'b0;
    read_expect("REG_STATUS set", REG_STATUS, 32'd1);
    read_expect("REG_STATUS sticky", REG_STATUS, 32'd1);
    up_write(REG_STATUS, 32'd1);
    read_expect("REG_STATUS cleared", REG_STATUS, 32'd0);
  endtask

  // ************************************************
  // Main sequence
  // ************************************************
  initial begin
    seed     = 32'hf6e9b115;
    up_clk   = 1'b0;
    up_rstn  = 1'b0;
    up_wreq  = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq  = 1'b0;
    up_raddr = '0;
    dac_dunf = 1'b0;
    ext_data = '0;
    repeat (4) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;
    tick();

    test_register_access();
    test_ramp();
    test_pattern_sync();
    test_ext_format();
    test_underflow();

    $display("TEST OK");
    $finish;
  end

endmodule

//--- dac_tpl.f
hdl/dac_tpl_pkg.sv
hdl/dac_tpl_common_regs.sv
hdl/dac_tpl_channel_regs.sv
hdl/dac_tpl_chan_source.sv
hdl/dac_tpl_regmap.sv
hdl/dac_tpl_top.sv
test/dac_tpl_tb.sv

//--- Makefile
# Verilator build and run for the DAC transport layer testbench

VERILATOR ?= verilator
TOP       ?= dac_tpl_tb
FILELIST  ?= dac_tpl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status alone is not enough
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
